// File: hw/memmap_settings.svh
`ifndef MEMMAP_SETTINGS_SVH
`define MEMMAP_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Region base addresses
////////////////////////////////////////////////////////////

// Program space is everything below the sprite base
`define MM_SPRITE_BASE      16'h2000
`define MM_TILE_BASE        16'h2400
`define MM_PALETTE_BASE     16'h4400

// Register block with exact address matches only
`define MM_REG_BASE         16'h4800
`define MM_PRIORITY_ADDR    16'h4801
`define MM_BRIGHTNESS_ADDR  16'h4802
`define MM_SWITCH_LED_ADDR  16'h4803

////////////////////////////////////////////////////////////
// Memory depths in 16-bit words
////////////////////////////////////////////////////////////

`define MM_PROGRAM_DEPTH    8192
`define MM_SPRITE_DEPTH     1024
`define MM_TILE_DEPTH       8192
`define MM_PALETTE_DEPTH    1024

`endif

// File: hw/memmap_pkg.sv
`default_nettype none

package memmap_pkg;

	// Targets of the processor data port
	typedef enum logic [2:0] {
		region_program  = 3'd0,
		region_sprite   = 3'd1,
		region_tile     = 3'd2,
		region_palette  = 3'd3,
		region_regs     = 3'd4,
		region_unmapped = 3'd5
	} region_e;

	// Raw request as driven by the processor
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        we;
	} mem_req_t;

	// Stage 1 output shared by all four RAMs and the register block
	typedef struct packed {
		logic        valid;
		logic        we;
		region_e     region;
		logic [12:0] offset;
		logic [15:0] addr;
		logic [15:0] wdata;
	} decoded_req_t;

	// Travels with the stage 2 reads so stage 3 knows who answers
	typedef struct packed {
		logic    valid;
		region_e region;
	} return_tag_t;

endpackage

`default_nettype wire

// File: hw/addr_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "memmap_settings.svh"

module addr_decode (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      mem_req,
	input  memmap_pkg::mem_req_t     req,
	output memmap_pkg::decoded_req_t dreq
);

	import memmap_pkg::*;

	region_e     region;
	logic [12:0] region_base;
	logic [12:0] offset;

	////////////////////////////////////////////////////////////
	// Region classification
	////////////////////////////////////////////////////////////

	always_comb begin
		if (req.addr < `MM_SPRITE_BASE) begin
			region      = region_program;
			region_base = 13'd0;
		end else if (req.addr < `MM_TILE_BASE) begin
			region      = region_sprite;
			region_base = 13'(`MM_SPRITE_BASE);
		end else if (req.addr < `MM_PALETTE_BASE) begin
			region      = region_tile;
			region_base = 13'(`MM_TILE_BASE);
		end else if (req.addr < `MM_REG_BASE) begin
			region      = region_palette;
			region_base = 13'(`MM_PALETTE_BASE);
		end else if (req.addr <= `MM_SWITCH_LED_ADDR) begin
			region      = region_regs;
			region_base = 13'(`MM_REG_BASE);
		end else begin
			region      = region_unmapped;
			region_base = 13'd0;
		end
	end

	// Every region is at most 8K words, so a 13-bit wrap is exact
	assign offset = req.addr[12:0] - region_base;

	////////////////////////////////////////////////////////////
	// Stage 1 register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			dreq.valid <= 1'b0;
		end else begin
			dreq.valid  <= mem_req;
			dreq.we     <= req.we;
			dreq.region <= region;
			dreq.offset <= offset;
			dreq.addr   <= req.addr;
			dreq.wdata  <= req.wdata;
		end
	end

endmodule

`default_nettype wire

// File: hw/word_ram.sv
`timescale 1ns/1ns
`default_nettype none

module word_ram #(
	parameter int DEPTH  = 1024,
	parameter int ADDR_W = 10
) (
	input  wire              clk,
	// Read-write port for the processor
	input  wire              a_en,
	input  wire              a_we,
	input  wire [ADDR_W-1:0] a_addr,
	input  wire [15:0]       a_wdata,
	output logic [15:0]      a_rdata,
	// Read-only port for fetch or video
	input  wire [ADDR_W-1:0] b_addr,
	output logic [15:0]      b_rdata
);

	logic [15:0] mem [DEPTH];

	////////////////////////////////////////////////////////////
	// Port A
	////////////////////////////////////////////////////////////

	// Read-first with the output held while the port is idle
	always_ff @(posedge clk) begin
		if (a_en) begin
			if (a_we) begin
				mem[a_addr] <= a_wdata;
			end
			a_rdata <= mem[a_addr];
		end
	end

	////////////////////////////////////////////////////////////
	// Port B
	////////////////////////////////////////////////////////////

	// Free-running read
	always_ff @(posedge clk) begin
		b_rdata <= mem[b_addr];
	end

endmodule

`default_nettype wire

// File: hw/mmio_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "memmap_settings.svh"

module mmio_regs (
	input  wire                      clk,
	input  wire                      rst,
	input  memmap_pkg::decoded_req_t dreq,
	input  wire                      hbright,
	input  wire                      vbright,
	input  wire [3:0]                switches,
	output logic [7:0]               brightness,
	output logic [6:0]               sprite_priority,
	output logic [7:0]               led_out,
	output logic [15:0]              reg_rdata,
	output memmap_pkg::return_tag_t  tag
);

	import memmap_pkg::*;

	logic        reg_access;
	logic [15:0] readback;

	assign reg_access = dreq.valid && (dreq.region == region_regs);

	////////////////////////////////////////////////////////////
	// Control registers
	////////////////////////////////////////////////////////////

	// Status register is read only
	always_ff @(posedge clk) begin
		if (!rst) begin
			brightness      <= 8'd0;
			sprite_priority <= 7'd0;
			led_out         <= 8'd0;
		end else if (reg_access && dreq.we) begin
			case (dreq.addr)
				`MM_BRIGHTNESS_ADDR: brightness      <= dreq.wdata[7:0];
				`MM_PRIORITY_ADDR:   sprite_priority <= dreq.wdata[6:0];
				`MM_SWITCH_LED_ADDR: led_out         <= dreq.wdata[7:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Readback and return tag
	////////////////////////////////////////////////////////////

	// Raster flags and switches are sampled here in stage 2
	always_comb begin
		case (dreq.addr)
			`MM_REG_BASE:        readback = {6'd0, hbright, vbright, 8'd0};
			`MM_PRIORITY_ADDR:   readback = {9'd0, sprite_priority};
			`MM_BRIGHTNESS_ADDR: readback = {8'd0, brightness};
			`MM_SWITCH_LED_ADDR: readback = {12'd0, switches};
			default:             readback = 16'd0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reg_access) begin
			reg_rdata <= readback;
		end
	end

	// Only reads come back and writes retire here
	always_ff @(posedge clk) begin
		if (!rst) begin
			tag.valid <= 1'b0;
		end else begin
			tag.valid  <= dreq.valid && !dreq.we;
			tag.region <= dreq.region;
		end
	end

endmodule

`default_nettype wire

// File: hw/read_return.sv
`timescale 1ns/1ns
`default_nettype none

module read_return (
	input  wire                     clk,
	input  wire                     rst,
	input  memmap_pkg::return_tag_t tag,
	input  wire [15:0]              program_rdata,
	input  wire [15:0]              sprite_rdata,
	input  wire [15:0]              tile_rdata,
	input  wire [15:0]              palette_rdata,
	input  wire [15:0]              reg_rdata,
	output logic                    rd_valid,
	output logic [15:0]             rd_data
);

	import memmap_pkg::*;

	logic [15:0] selected;

	// Unmapped addresses read as zero
	always_comb begin
		case (tag.region)
			region_program: selected = program_rdata;
			region_sprite:  selected = sprite_rdata;
			region_tile:    selected = tile_rdata;
			region_palette: selected = palette_rdata;
			region_regs:    selected = reg_rdata;
			default:        selected = 16'd0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Stage 3 register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= tag.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (tag.valid) begin
			rd_data <= selected;
		end
	end

endmodule

`default_nettype wire

// File: hw/memory_map_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "memmap_settings.svh"

module memory_map_top (
	input  wire                  clk,
	input  wire                  rst,
	// Processor data port
	input  wire                  mem_req,
	input  memmap_pkg::mem_req_t req,
	output logic                 rd_valid,
	output logic [15:0]          rd_data,
	// Instruction fetch
	input  wire [12:0]           pc_addr,
	output logic [15:0]          instruction,
	// Graphics read ports
	input  wire [9:0]            sprite_rd_addr,
	output logic [15:0]          sprite_rd_data,
	input  wire [12:0]           tile_rd_addr,
	output logic [15:0]          tile_rd_data,
	input  wire [9:0]            palette_rd_addr,
	output logic [15:0]          palette_rd_data,
	// Status inputs and control outputs
	input  wire                  hbright,
	input  wire                  vbright,
	input  wire [3:0]            switches,
	output logic [7:0]           brightness,
	output logic [6:0]           sprite_priority,
	output logic [7:0]           led_out
);

	import memmap_pkg::*;

	decoded_req_t dreq;
	return_tag_t  tag;
	logic [15:0]  program_rdata;
	logic [15:0]  sprite_rdata;
	logic [15:0]  tile_rdata;
	logic [15:0]  palette_rdata;
	logic [15:0]  reg_rdata;

	////////////////////////////////////////////////////////////
	// Stage 1
	////////////////////////////////////////////////////////////

	addr_decode u_decode (
		.clk     (clk),
		.rst     (rst),
		.mem_req (mem_req),
		.req     (req),
		.dreq    (dreq)
	);

	////////////////////////////////////////////////////////////
	// Stage 2
	////////////////////////////////////////////////////////////

	// Each RAM answers only for its own region
	word_ram #(.DEPTH(`MM_PROGRAM_DEPTH), .ADDR_W($clog2(`MM_PROGRAM_DEPTH))) u_program_ram (
		.clk     (clk),
		.a_en    (dreq.valid && (dreq.region == region_program)),
		.a_we    (dreq.we),
		.a_addr  (dreq.offset),
		.a_wdata (dreq.wdata),
		.a_rdata (program_rdata),
		.b_addr  (pc_addr),
		.b_rdata (instruction)
	);

	word_ram #(.DEPTH(`MM_SPRITE_DEPTH), .ADDR_W($clog2(`MM_SPRITE_DEPTH))) u_sprite_ram (
		.clk     (clk),
		.a_en    (dreq.valid && (dreq.region == region_sprite)),
		.a_we    (dreq.we),
		.a_addr  (dreq.offset[9:0]),
		.a_wdata (dreq.wdata),
		.a_rdata (sprite_rdata),
		.b_addr  (sprite_rd_addr),
		.b_rdata (sprite_rd_data)
	);

	word_ram #(.DEPTH(`MM_TILE_DEPTH), .ADDR_W($clog2(`MM_TILE_DEPTH))) u_tile_ram (
		.clk     (clk),
		.a_en    (dreq.valid && (dreq.region == region_tile)),
		.a_we    (dreq.we),
		.a_addr  (dreq.offset),
		.a_wdata (dreq.wdata),
		.a_rdata (tile_rdata),
		.b_addr  (tile_rd_addr),
		.b_rdata (tile_rd_data)
	);

	word_ram #(.DEPTH(`MM_PALETTE_DEPTH), .ADDR_W($clog2(`MM_PALETTE_DEPTH))) u_palette_ram (
		.clk     (clk),
		.a_en    (dreq.valid && (dreq.region == region_palette)),
		.a_we    (dreq.we),
		.a_addr  (dreq.offset[9:0]),
		.a_wdata (dreq.wdata),
		.a_rdata (palette_rdata),
		.b_addr  (palette_rd_addr),
		.b_rdata (palette_rd_data)
	);

	mmio_regs u_regs (
		.clk             (clk),
		.rst             (rst),
		.dreq            (dreq),
		.hbright         (hbright),
		.vbright         (vbright),
		.switches        (switches),
		.brightness      (brightness),
		.sprite_priority (sprite_priority),
		.led_out         (led_out),
		.reg_rdata       (reg_rdata),
		.tag             (tag)
	);

	////////////////////////////////////////////////////////////
	// Stage 3
	////////////////////////////////////////////////////////////

	read_return u_return (
		.clk           (clk),
		.rst           (rst),
		.tag           (tag),
		.program_rdata (program_rdata),
		.sprite_rdata  (sprite_rdata),
		.tile_rdata    (tile_rdata),
		.palette_rdata (palette_rdata),
		.reg_rdata     (reg_rdata),
		.rd_valid      (rd_valid),
		.rd_data       (rd_data)
	);

endmodule

`default_nettype wire

// File: tb/memory_map_properties.sv
`timescale 1ns/1ns
`default_nettype none

module memory_map_properties (
	input wire                  clk,
	input wire                  rst,
	input wire                  mem_req,
	input memmap_pkg::mem_req_t req,
	input wire                  rd_valid
);

	////////////////////////////////////////////////////////////
	// Data port timing
	////////////////////////////////////////////////////////////

	// Three register stages between request and result
	read_returns: assert property (@(posedge clk) disable iff (!rst)
		(mem_req && !req.we) |-> ##3 rd_valid)
		else $error("read request not answered three cycles later");

	// Writes retire silently
	write_silent: assert property (@(posedge clk) disable iff (!rst)
		(mem_req && req.we) |-> ##3 !rd_valid)
		else $error("write request produced a read result");

	// Reset is synchronous, so the output is low from the next cycle on
	reset_quiet: assert property (@(posedge clk)
		!rst |=> !rd_valid)
		else $error("rd_valid high during reset");

endmodule

bind memory_map_top memory_map_properties u_props (
	.clk      (clk),
	.rst      (rst),
	.mem_req  (mem_req),
	.req      (req),
	.rd_valid (rd_valid)
);

`default_nettype wire

// File: tb/memory_map_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "memmap_settings.svh"

module memory_map_tb;

	import memmap_pkg::*;

	logic        clk;
	logic        rst;
	logic        mem_req;
	mem_req_t    req;
	logic        rd_valid;
	logic [15:0] rd_data;
	logic [12:0] pc_addr;
	logic [15:0] instruction;
	logic [9:0]  sprite_rd_addr;
	logic [15:0] sprite_rd_data;
	logic [12:0] tile_rd_addr;
	logic [15:0] tile_rd_data;
	logic [9:0]  palette_rd_addr;
	logic [15:0] palette_rd_data;
	logic        hbright;
	logic        vbright;
	logic [3:0]  switches;
	logic [7:0]  brightness;
	logic [6:0]  sprite_priority;
	logic [7:0]  led_out;

	// Reference model with memories keyed by full address
	logic [15:0] model_mem [logic [15:0]];
	logic [7:0]  m_bright;
	logic [6:0]  m_prio;
	logic [7:0]  m_led;
	logic [15:0] expect_q [$];
	logic [15:0] exp_instr;
	logic [15:0] exp_sprite;
	logic [15:0] exp_tile;
	logic [15:0] exp_palette;

	logic [31:0] rng_state;
	int          errors;
	int          checks;
	int          max_in_flight;

	memory_map_top UUT (
		.clk             (clk),
		.rst             (rst),
		.mem_req         (mem_req),
		.req             (req),
		.rd_valid        (rd_valid),
		.rd_data         (rd_data),
		.pc_addr         (pc_addr),
		.instruction     (instruction),
		.sprite_rd_addr  (sprite_rd_addr),
		.sprite_rd_data  (sprite_rd_data),
		.tile_rd_addr    (tile_rd_addr),
		.tile_rd_data    (tile_rd_data),
		.palette_rd_addr (palette_rd_addr),
		.palette_rd_data (palette_rd_data),
		.hbright         (hbright),
		.vbright         (vbright),
		.switches        (switches),
		.brightness      (brightness),
		.sprite_priority (sprite_priority),
		.led_out         (led_out)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic logic [15:0] region_base(input int region);
		case (region)
			1:       return `MM_SPRITE_BASE;
			2:       return `MM_TILE_BASE;
			3:       return `MM_PALETTE_BASE;
			default: return 16'h0000;
		endcase
	endfunction

	// 16 slots per region including the first and last word
	function automatic int slot_offset(input int region, input logic [3:0] slot);
		int depth;
		case (region)
			1:       depth = `MM_SPRITE_DEPTH;
			2:       depth = `MM_TILE_DEPTH;
			3:       depth = `MM_PALETTE_DEPTH;
			default: depth = `MM_PROGRAM_DEPTH;
		endcase
		return (int'(slot) * (depth - 1)) / 15;
	endfunction

	function automatic logic [15:0] addr_for(input int region, input logic [3:0] slot);
		return region_base(region) + 16'(slot_offset(region, slot));
	endfunction

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
		end
	endtask

	// Memory map rules applied in request order
	task automatic model_access(input logic we, input logic [15:0] addr,
			input logic [15:0] data, output logic [15:0] rdata);
		rdata = 16'h0000;
		if (addr < `MM_REG_BASE) begin
			if (we)
				model_mem[addr] = data;
			else
				rdata = model_mem[addr];
		end else if (addr == `MM_REG_BASE) begin
			rdata[9] = hbright;
			rdata[8] = vbright;
		end else if (addr == `MM_PRIORITY_ADDR) begin
			if (we)
				m_prio = data[6:0];
			rdata = {9'd0, m_prio};
		end else if (addr == `MM_BRIGHTNESS_ADDR) begin
			if (we)
				m_bright = data[7:0];
			rdata = {8'd0, m_bright};
		end else if (addr == `MM_SWITCH_LED_ADDR) begin
			if (we)
				m_led = data[7:0];
			rdata = {12'd0, switches};
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and result checking
	////////////////////////////////////////////////////////////

	// Advance one falling edge and collect any read result
	task automatic tick();
		@(negedge clk);
		if (rd_valid) begin
			if (expect_q.size() == 0) begin
				errors++;
				$display("ERROR: rd_valid pulse with no read outstanding");
			end else begin
				check("rd_data", rd_data, expect_q.pop_front());
			end
		end
		mem_req = 1'b0;
	endtask

	task automatic drive_video_addrs(input logic record);
		logic [31:0] r;
		r = rand32();
		pc_addr         = 13'(slot_offset(0, r[3:0]));
		sprite_rd_addr  = 10'(slot_offset(1, r[7:4]));
		tile_rd_addr    = 13'(slot_offset(2, r[11:8]));
		palette_rd_addr = 10'(slot_offset(3, r[15:12]));
		if (record) begin
			exp_instr   = model_mem[addr_for(0, r[3:0])];
			exp_sprite  = model_mem[addr_for(1, r[7:4])];
			exp_tile    = model_mem[addr_for(2, r[11:8])];
			exp_palette = model_mem[addr_for(3, r[15:12])];
		end
	endtask

	task automatic issue(input logic we, input logic [15:0] addr, input logic [15:0] data);
		logic [15:0] expected;
		tick();
		model_access(we, addr, data, expected);
		mem_req   = 1'b1;
		req.we    = we;
		req.addr  = addr;
		req.wdata = data;
		drive_video_addrs(1'b0);
		if (!we) begin
			expect_q.push_back(expected);
			if (expect_q.size() > max_in_flight)
				max_in_flight = expect_q.size();
		end
	endtask

	task automatic random_op();
		logic [31:0] r;
		logic [31:0] g;
		logic [15:0] addr;
		r = rand32();
		g = rand32();
		if (r[3:0] < 4'd12)
			addr = addr_for(int'(r[1:0]), r[8:5]);
		else if (r[3:0] < 4'd15)
			addr = `MM_REG_BASE + {14'd0, r[6:5]};
		else if (r[9])
			addr = 16'hFFFF - {5'd0, r[15:5]};
		else
			addr = `MM_SWITCH_LED_ADDR + 16'd1 + {5'd0, r[15:5]};
		issue(r[4], addr, g[15:0]);
		// Read straight back behind some memory writes
		if (r[3:0] < 4'd12 && r[4] && r[10])
			issue(1'b0, addr, 16'h0000);
		if (g[18:16] == 3'd0)
			tick();
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (expect_q.size() != 0 && waited < 50) begin
			tick();
			waited++;
		end
		if (expect_q.size() != 0) begin
			errors++;
			$display("ERROR: %0d read results never arrived", expect_q.size());
			expect_q.delete();
		end
		// Catch late stray pulses
		repeat (4) tick();
	endtask

	task automatic video_check(input int cycles);
		int n;
		drive_video_addrs(1'b1);
		for (n = 0; n < cycles; n++) begin
			tick();
			check("instruction", instruction, exp_instr);
			check("sprite_rd_data", sprite_rd_data, exp_sprite);
			check("tile_rd_data", tile_rd_data, exp_tile);
			check("palette_rd_data", palette_rd_data, exp_palette);
			drive_video_addrs(1'b1);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int region;
		int slot;
		int round;
		int i;
		logic [31:0] r;
		clk             = 1'b0;
		rst             = 1'b0;
		mem_req         = 1'b0;
		req             = '0;
		pc_addr         = '0;
		sprite_rd_addr  = '0;
		tile_rd_addr    = '0;
		palette_rd_addr = '0;
		hbright         = 1'b0;
		vbright         = 1'b0;
		switches        = 4'd0;
		rng_state       = 32'd1505;
		errors          = 0;
		checks          = 0;
		max_in_flight   = 0;
		m_bright        = 8'd0;
		m_prio          = 7'd0;
		m_led           = 8'd0;

		repeat (10) @(negedge clk);
		check("rd_valid", {15'd0, rd_valid}, 16'h0000);
		check("brightness", {8'd0, brightness}, 16'h0000);
		check("sprite_priority", {9'd0, sprite_priority}, 16'h0000);
		check("led_out", {8'd0, led_out}, 16'h0000);
		rst = 1'b1;

		// Every slot gets a known value before any read
		for (region = 0; region < 4; region++) begin
			for (slot = 0; slot < 16; slot++) begin
				r = rand32();
				issue(1'b1, addr_for(region, 4'(slot)), r[15:0]);
			end
		end
		drain();

		// Status inputs only move while the pipeline is empty
		// Four rounds walk all combinations of the two raster flags
		for (round = 0; round < 4; round++) begin
			r = rand32();
			hbright  = round[0];
			vbright  = round[1];
			switches = r[5:2];
			for (i = 0; i < 150; i++)
				random_op();
			drain();
			check("brightness", {8'd0, brightness}, {8'd0, m_bright});
			check("sprite_priority", {9'd0, sprite_priority}, {9'd0, m_prio});
			check("led_out", {8'd0, led_out}, {8'd0, m_led});
		end

		video_check(64);
		check("max_in_flight", 16'(max_in_flight), 16'd3);

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/memmap_pkg.sv
hw/addr_decode.sv
hw/word_ram.sv
hw/mmio_regs.sv
hw/read_return.sv
hw/memory_map_top.sv
tb/memory_map_properties.sv
tb/memory_map_tb.sv

// File: Makefile
# Verilator flow for the memory map testbench
# Any variable can be overridden, e.g. make sim TOP=memory_map_tb LOG=run.log

VERILATOR ?= verilator
TOP       ?= memory_map_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides the result, whatever the simulator's exit status was
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
